/* rtl/bus_pkg.sv */
package bus_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // on-chip word memory
    localparam int MEM_WORDS   = 1024;
    localparam int MEM_INDEX_W = $clog2(MEM_WORDS);
    localparam int WORD_LSB    = 2;               // byte offset inside a 32-bit word

    typedef logic [MEM_INDEX_W-1:0] mem_index_t;  // address bits 11..2

    // cycles from AR handshake to rvalid, at least 2
    localparam int MEM_LATENCY = 2;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY);

    typedef logic [LAT_CNT_W-1:0] lat_cnt_t;

    // arbiter state, also the router select
    typedef enum logic [2:0] {
        GRANT_NONE,
        GRANT_IFU_RD,
        GRANT_LSU_RD,
        GRANT_LSU_WR,
        GRANT_RELEASE   // dead cycle between owners
    } grant_e;

    // upper address bits are dropped so addresses alias modulo the memory
    function automatic mem_index_t word_index(addr_t addr);
        return addr[WORD_LSB +: MEM_INDEX_W];
    endfunction

endpackage

/* rtl/bus_arbiter.sv */
module bus_arbiter (
    input  logic             clk,
    input  logic             rst,

    // request sources, sampled only while idle
    input  logic             ifu_arvalid,
    input  logic             lsu_arvalid,
    input  logic             lsu_awvalid,
    input  logic             lsu_wvalid,

    // slave side response channels, watched for completion
    input  logic             saxi_rvalid,
    input  logic             saxi_rready,
    input  logic             saxi_bvalid,
    input  logic             saxi_bready,

    output bus_pkg::grant_e  grant
);
    import bus_pkg::*;

    grant_e grant_q;
    grant_e grant_nxt;

    logic   wr_req;
    logic   rd_done;
    logic   wr_done;

    // lsu write counts as requested once either half shows up
    assign wr_req  = lsu_awvalid | lsu_wvalid;

    assign rd_done = saxi_rvalid & saxi_rready;     // R handshake ends a read
    assign wr_done = saxi_bvalid & saxi_bready;     // B handshake ends a write

    // fixed priority, grant held until the owner's response completes
    always_comb begin
        grant_nxt = grant_q;
        case (grant_q)
            GRANT_NONE: begin
                if (ifu_arvalid) begin
                    grant_nxt = GRANT_IFU_RD;
                end else if (lsu_arvalid) begin
                    grant_nxt = GRANT_LSU_RD;
                end else if (wr_req) begin
                    grant_nxt = GRANT_LSU_WR;
                end
            end

            GRANT_IFU_RD,
            GRANT_LSU_RD: begin
                if (rd_done) begin
                    grant_nxt = GRANT_RELEASE;
                end
            end

            GRANT_LSU_WR: begin
                if (wr_done) begin
                    grant_nxt = GRANT_RELEASE;
                end
            end

            GRANT_RELEASE: begin
                grant_nxt = GRANT_NONE;   // always exactly one cycle
            end

            default: begin
                grant_nxt = GRANT_NONE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= GRANT_NONE;
        end else begin
            grant_q <= grant_nxt;
        end
    end

    // registered, so the grant lags the request by one cycle
    assign grant = grant_q;

endmodule

/* rtl/bus_router.sv */
module bus_router (
    input  bus_pkg::grant_e grant,

    // ifu read master
    input  bus_pkg::addr_t  ifu_araddr,
    input  logic            ifu_arvalid,
    output logic            ifu_arready,
    output logic            ifu_rvalid,
    output bus_pkg::data_t  ifu_rdata,
    input  logic            ifu_rready,

    // lsu master
    input  bus_pkg::addr_t  lsu_araddr,
    input  logic            lsu_arvalid,
    output logic            lsu_arready,
    output logic            lsu_rvalid,
    output bus_pkg::data_t  lsu_rdata,
    input  logic            lsu_rready,
    input  bus_pkg::addr_t  lsu_awaddr,
    input  logic            lsu_awvalid,
    output logic            lsu_awready,
    input  bus_pkg::data_t  lsu_wdata,
    input  logic            lsu_wvalid,
    output logic            lsu_wready,
    output logic            lsu_bvalid,
    input  logic            lsu_bready,

    // slave port
    output bus_pkg::addr_t  saxi_araddr,
    output logic            saxi_arvalid,
    input  logic            saxi_arready,
    input  logic            saxi_rvalid,
    input  bus_pkg::data_t  saxi_rdata,
    output logic            saxi_rready,
    output bus_pkg::addr_t  saxi_awaddr,
    output logic            saxi_awvalid,
    input  logic            saxi_awready,
    output bus_pkg::data_t  saxi_wdata,
    output logic            saxi_wvalid,
    input  logic            saxi_wready,
    input  logic            saxi_bvalid,
    output logic            saxi_bready
);
    import bus_pkg::*;

    always_comb begin
        // parked values, also what an ungranted master sees
        saxi_araddr  = '0;
        saxi_arvalid = 1'b0;
        saxi_rready  = 1'b0;
        saxi_awaddr  = '0;
        saxi_awvalid = 1'b0;
        saxi_wdata   = '0;
        saxi_wvalid  = 1'b0;
        saxi_bready  = 1'b0;

        ifu_arready  = 1'b0;
        ifu_rvalid   = 1'b0;
        ifu_rdata    = '0;

        lsu_arready  = 1'b0;
        lsu_rvalid   = 1'b0;
        lsu_rdata    = '0;
        lsu_awready  = 1'b0;
        lsu_wready   = 1'b0;
        lsu_bvalid   = 1'b0;

        case (grant)
            GRANT_IFU_RD: begin
                saxi_araddr  = ifu_araddr;
                saxi_arvalid = ifu_arvalid;
                saxi_rready  = ifu_rready;
                ifu_arready  = saxi_arready;
                ifu_rvalid   = saxi_rvalid;
                ifu_rdata    = saxi_rdata;
            end

            GRANT_LSU_RD: begin
                saxi_araddr  = lsu_araddr;
                saxi_arvalid = lsu_arvalid;
                saxi_rready  = lsu_rready;
                lsu_arready  = saxi_arready;
                lsu_rvalid   = saxi_rvalid;
                lsu_rdata    = saxi_rdata;
            end

            GRANT_LSU_WR: begin
                // AW and W travel together, memory takes them in one cycle
                saxi_awaddr  = lsu_awaddr;
                saxi_awvalid = lsu_awvalid;
                saxi_wdata   = lsu_wdata;
                saxi_wvalid  = lsu_wvalid;
                saxi_bready  = lsu_bready;
                lsu_awready  = saxi_awready;
                lsu_wready   = saxi_wready;
                lsu_bvalid   = saxi_bvalid;
            end

            default: begin
                // idle and release keep the parked values
            end
        endcase
    end

endmodule

/* rtl/axi_sram.sv */
module axi_sram (
    input  logic            clk,
    input  logic            rst,

    // read address
    input  bus_pkg::addr_t  araddr,
    input  logic            arvalid,
    output logic            arready,

    // read data
    output logic            rvalid,
    output bus_pkg::data_t  rdata,
    input  logic            rready,

    // write address and data, accepted together
    input  bus_pkg::addr_t  awaddr,
    input  logic            awvalid,
    output logic            awready,
    input  bus_pkg::data_t  wdata,
    input  logic            wvalid,
    output logic            wready,

    // write response
    output logic            bvalid,
    input  logic            bready
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_RD_WAIT,
        SRAM_RD_RESP,
        SRAM_WR_RESP
    } sram_state_e;

    sram_state_e state;
    sram_state_e state_nxt;

    lat_cnt_t    lat_cnt;          // wait cycles left before the response
    mem_index_t  rd_idx;           // captured at the AR handshake
    data_t       rdata_q;
    data_t       mem [MEM_WORDS];

    logic        ar_fire;
    logic        wr_fire;
    logic        r_fire;
    logic        b_fire;
    logic        lat_done;

    assign arready = (state == SRAM_IDLE);

    // both halves of a write must be present, a read wins a tie
    assign awready = (state == SRAM_IDLE) && awvalid && wvalid && !arvalid;
    assign wready  = awready;

    assign rvalid  = (state == SRAM_RD_RESP);
    assign bvalid  = (state == SRAM_WR_RESP);
    assign rdata   = rdata_q;      // held while waiting on rready

    assign ar_fire  = arvalid && arready;
    assign wr_fire  = awvalid && awready && wvalid && wready;
    assign r_fire   = rvalid && rready;
    assign b_fire   = bvalid && bready;
    assign lat_done = (lat_cnt == lat_cnt_t'(1));

    always_comb begin
        state_nxt = state;
        case (state)
            SRAM_IDLE: begin
                if (ar_fire) begin
                    state_nxt = SRAM_RD_WAIT;
                end else if (wr_fire) begin
                    state_nxt = SRAM_WR_RESP;
                end
            end

            SRAM_RD_WAIT: begin
                if (lat_done) begin
                    state_nxt = SRAM_RD_RESP;
                end
            end

            SRAM_RD_RESP: begin
                if (r_fire) begin
                    state_nxt = SRAM_IDLE;
                end
            end

            SRAM_WR_RESP: begin
                if (b_fire) begin
                    state_nxt = SRAM_IDLE;
                end
            end

            default: begin
                state_nxt = SRAM_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= SRAM_IDLE;
            lat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (ar_fire) begin
                lat_cnt <= lat_cnt_t'(MEM_LATENCY - 1);   // AR cycle counts as one
            end else if ((state == SRAM_RD_WAIT) && !lat_done) begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    // read path, word picked up on the last wait cycle
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rd_idx <= word_index(araddr);
        end
        if ((state == SRAM_RD_WAIT) && lat_done) begin
            rdata_q <= mem[rd_idx];
        end
    end

    // write path
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[word_index(awaddr)] <= wdata;
        end
    end

endmodule

/* rtl/mem_subsys_top.sv */
module mem_subsys_top (
    input  logic            clk,
    input  logic            rst,

    // ifu read port
    input  bus_pkg::addr_t  ifu_araddr,
    input  logic            ifu_arvalid,
    output logic            ifu_arready,
    output logic            ifu_rvalid,
    output bus_pkg::data_t  ifu_rdata,
    input  logic            ifu_rready,

    // lsu read and write port
    input  bus_pkg::addr_t  lsu_araddr,
    input  logic            lsu_arvalid,
    output logic            lsu_arready,
    output logic            lsu_rvalid,
    output bus_pkg::data_t  lsu_rdata,
    input  logic            lsu_rready,
    input  bus_pkg::addr_t  lsu_awaddr,
    input  logic            lsu_awvalid,
    output logic            lsu_awready,
    input  bus_pkg::data_t  lsu_wdata,
    input  logic            lsu_wvalid,
    output logic            lsu_wready,
    output logic            lsu_bvalid,
    input  logic            lsu_bready
);
    import bus_pkg::*;

    grant_e grant;

    // slave side between router and memory
    addr_t  saxi_araddr;
    logic   saxi_arvalid;
    logic   saxi_arready;
    logic   saxi_rvalid;
    data_t  saxi_rdata;
    logic   saxi_rready;
    addr_t  saxi_awaddr;
    logic   saxi_awvalid;
    logic   saxi_awready;
    data_t  saxi_wdata;
    logic   saxi_wvalid;
    logic   saxi_wready;
    logic   saxi_bvalid;
    logic   saxi_bready;

    bus_arbiter arb0 (
        .clk         (clk),
        .rst         (rst),
        .ifu_arvalid (ifu_arvalid),
        .lsu_arvalid (lsu_arvalid),
        .lsu_awvalid (lsu_awvalid),
        .lsu_wvalid  (lsu_wvalid),
        .saxi_rvalid (saxi_rvalid),
        .saxi_rready (saxi_rready),
        .saxi_bvalid (saxi_bvalid),
        .saxi_bready (saxi_bready),
        .grant       (grant)
    );

    bus_router rtr0 (
        .grant        (grant),
        .ifu_araddr   (ifu_araddr),
        .ifu_arvalid  (ifu_arvalid),
        .ifu_arready  (ifu_arready),
        .ifu_rvalid   (ifu_rvalid),
        .ifu_rdata    (ifu_rdata),
        .ifu_rready   (ifu_rready),
        .lsu_araddr   (lsu_araddr),
        .lsu_arvalid  (lsu_arvalid),
        .lsu_arready  (lsu_arready),
        .lsu_rvalid   (lsu_rvalid),
        .lsu_rdata    (lsu_rdata),
        .lsu_rready   (lsu_rready),
        .lsu_awaddr   (lsu_awaddr),
        .lsu_awvalid  (lsu_awvalid),
        .lsu_awready  (lsu_awready),
        .lsu_wdata    (lsu_wdata),
        .lsu_wvalid   (lsu_wvalid),
        .lsu_wready   (lsu_wready),
        .lsu_bvalid   (lsu_bvalid),
        .lsu_bready   (lsu_bready),
        .saxi_araddr  (saxi_araddr),
        .saxi_arvalid (saxi_arvalid),
        .saxi_arready (saxi_arready),
        .saxi_rvalid  (saxi_rvalid),
        .saxi_rdata   (saxi_rdata),
        .saxi_rready  (saxi_rready),
        .saxi_awaddr  (saxi_awaddr),
        .saxi_awvalid (saxi_awvalid),
        .saxi_awready (saxi_awready),
        .saxi_wdata   (saxi_wdata),
        .saxi_wvalid  (saxi_wvalid),
        .saxi_wready  (saxi_wready),
        .saxi_bvalid  (saxi_bvalid),
        .saxi_bready  (saxi_bready)
    );

    axi_sram mem0 (
        .clk     (clk),
        .rst     (rst),
        .araddr  (saxi_araddr),
        .arvalid (saxi_arvalid),
        .arready (saxi_arready),
        .rvalid  (saxi_rvalid),
        .rdata   (saxi_rdata),
        .rready  (saxi_rready),
        .awaddr  (saxi_awaddr),
        .awvalid (saxi_awvalid),
        .awready (saxi_awready),
        .wdata   (saxi_wdata),
        .wvalid  (saxi_wvalid),
        .wready  (saxi_wready),
        .bvalid  (saxi_bvalid),
        .bready  (saxi_bready)
    );

endmodule

/* sim/bus_checker.sv */
module bus_checker (
    input  logic            clk,
    input  logic            rst,

    // ifu read port of the DUT
    input  bus_pkg::addr_t  ifu_araddr,
    input  logic            ifu_arvalid,
    input  logic            ifu_arready,
    input  logic            ifu_rvalid,
    input  bus_pkg::data_t  ifu_rdata,
    input  logic            ifu_rready,

    // lsu port of the DUT
    input  bus_pkg::addr_t  lsu_araddr,
    input  logic            lsu_arvalid,
    input  logic            lsu_arready,
    input  logic            lsu_rvalid,
    input  bus_pkg::data_t  lsu_rdata,
    input  logic            lsu_rready,
    input  bus_pkg::addr_t  lsu_awaddr,
    input  logic            lsu_awvalid,
    input  logic            lsu_awready,
    input  bus_pkg::data_t  lsu_wdata,
    input  logic            lsu_wvalid,
    input  logic            lsu_wready,
    input  logic            lsu_bvalid,
    input  logic            lsu_bready,

    output int              error_count
);
    import bus_pkg::*;

    localparam int REQ_TO_RVALID = 3;   // grant cycle plus memory latency

    data_t      model [MEM_WORDS];
    bit         known [MEM_WORDS];

    // index 0 is the ifu and index 1 the lsu
    logic [1:0] arv;
    logic [1:0] arr;
    logic [1:0] rv;
    logic [1:0] rr;
    addr_t      ara [2];
    data_t      rd [2];
    logic [6:0] out_flags;

    logic [1:0] arv_q;
    logic [1:0] rv_q;
    logic [1:0] rr_q;
    data_t      rd_q [2];
    logic       any_q;               // some valid was high on the last edge
    bit   [1:0] pend;                // AR seen and R still outstanding
    int         rd_idx [2];
    int         req_cyc [2];         // -1 when the delay is not checked
    bit         wr_pend;
    int         wr_idx;
    data_t      wr_data;
    bit         ifu_first;
    bit         rst_q;
    int         cyc;
    int         last_done;
    int         errors = 0;

    assign arv       = {lsu_arvalid, ifu_arvalid};
    assign arr       = {lsu_arready, ifu_arready};
    assign rv        = {lsu_rvalid, ifu_rvalid};
    assign rr        = {lsu_rready, ifu_rready};
    assign ara[0]    = ifu_araddr;
    assign ara[1]    = lsu_araddr;
    assign rd[0]     = ifu_rdata;
    assign rd[1]     = lsu_rdata;
    assign out_flags = {ifu_arready, ifu_rvalid, lsu_arready, lsu_rvalid,
                        lsu_awready, lsu_wready, lsu_bvalid};

    assign error_count = errors;

    // word address from bits 11..2 so upper bits alias
    function automatic int to_index(input addr_t addr);
        return (addr >> 2) % MEM_WORDS;
    endfunction

    function automatic string who(input int m);
        return (m == 0) ? "ifu" : "lsu";
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAIL %s expected 0x%08h got 0x%08h", name, expected, actual);
        errors++;
    endtask

    task automatic protocol_error(input string what);
        $display("error at cycle %0d: %s", cyc, what);
        errors++;
    endtask

    always @(posedge clk) begin : watch
        bit quiet;
        int m;
        quiet = (pend == 2'b00) && !wr_pend && !any_q && (cyc >= last_done + 2);
        if (rst) begin
            if (rst_q && (out_flags !== 7'h00)) begin
                value_mismatch("ready/valid outputs in reset", 32'h0, {25'h0, out_flags});
            end
            rst_q      <= 1'b1;
            cyc        <= 0;
            last_done  <= -10;
            pend       <= '0;
            wr_pend    <= 1'b0;
            ifu_first  <= 1'b0;
            arv_q      <= '0;
            rv_q       <= '0;
            rr_q       <= '0;
            any_q      <= 1'b0;
            req_cyc[0] <= -1;
            req_cyc[1] <= -1;
        end else begin
            cyc <= cyc + 1;
            if (arv == 2'b11 && arv_q == 2'b00) begin
                ifu_first <= 1'b1;     // tie so the ifu must finish first
            end
            if (pend[0] && lsu_rvalid) begin
                protocol_error("lsu_rvalid high during an ifu read");
            end
            for (m = 0; m < 2; m++) begin
                if (arv[m] && !arv_q[m]) begin
                    req_cyc[m] <= (quiet && !(m == 1 && arv[0])) ? cyc : -1;
                end
                if (arv[m] && arr[m]) begin
                    rd_idx[m] <= to_index(ara[m]);
                    pend[m]   <= 1'b1;
                end
                if (rv[m] && !rv_q[m]) begin
                    if (!pend[m]) begin
                        protocol_error({who(m), " rvalid with no read outstanding"});
                    end else if (req_cyc[m] >= 0 && cyc - req_cyc[m] != REQ_TO_RVALID) begin
                        value_mismatch({who(m), "_rvalid delay"}, REQ_TO_RVALID,
                                       cyc - req_cyc[m]);
                    end
                end
                // back-pressure must hold the response
                if (rv_q[m] && !rr_q[m]) begin
                    if (rv[m] !== 1'b1) begin
                        value_mismatch({who(m), "_rvalid"}, 32'h1, {31'h0, rv[m]});
                    end else if (rd[m] !== rd_q[m]) begin
                        value_mismatch({who(m), "_rdata hold"}, rd_q[m], rd[m]);
                    end
                end
                if (rv[m] && rr[m]) begin
                    if (!known[rd_idx[m]]) begin
                        protocol_error({who(m), " read of a word never written"});
                    end else if (rd[m] !== model[rd_idx[m]]) begin
                        value_mismatch({who(m), "_rdata"}, model[rd_idx[m]], rd[m]);
                    end
                    if (m == 0) begin
                        ifu_first <= 1'b0;
                    end else if (ifu_first) begin
                        protocol_error("lsu read finished before the tied ifu read");
                    end
                    pend[m]   <= 1'b0;
                    last_done <= cyc;
                end
            end
            // AW and W are taken in the same cycle
            if (lsu_awready || lsu_wready) begin
                if (lsu_awready !== 1'b1) begin
                    value_mismatch("lsu_awready", 32'h1, {31'h0, lsu_awready});
                end
                if (lsu_wready !== 1'b1) begin
                    value_mismatch("lsu_wready", 32'h1, {31'h0, lsu_wready});
                end
            end
            if (lsu_awvalid && lsu_awready && lsu_wvalid && lsu_wready) begin
                wr_idx  <= to_index(lsu_awaddr);
                wr_data <= lsu_wdata;
                wr_pend <= 1'b1;
            end
            if (lsu_bvalid && lsu_bready) begin
                if (!wr_pend) begin
                    protocol_error("lsu write response without an accepted write");
                end else begin
                    model[wr_idx] <= wr_data;
                    known[wr_idx] <= 1'b1;
                end
                wr_pend   <= 1'b0;
                last_done <= cyc;
            end
            arv_q   <= arv;
            rv_q    <= rv;
            rr_q    <= rr;
            rd_q[0] <= rd[0];
            rd_q[1] <= rd[1];
            any_q   <= |{arv, lsu_awvalid, lsu_wvalid};
        end
    end

endmodule

/* sim/tb_mem_subsys.sv */
module tb_mem_subsys;
    import bus_pkg::*;

    localparam int TIMEOUT = 100;
    localparam int GAP     = 2;      // idle edges between transactions

    typedef struct packed {
        logic       is_lsu;
        logic       is_wr;
        addr_t      addr;
        data_t      data;
        logic [3:0] stall;           // rready held low this many cycles
    } op_t;

    typedef enum {ON_ARREADY, ON_RVALID, ON_AWREADY, ON_BVALID} wait_e;

    logic   clk;
    logic   rst;
    addr_t  ifu_araddr;
    logic   ifu_arvalid;
    logic   ifu_arready;
    logic   ifu_rvalid;
    data_t  ifu_rdata;
    logic   ifu_rready;
    addr_t  lsu_araddr;
    logic   lsu_arvalid;
    logic   lsu_arready;
    logic   lsu_rvalid;
    data_t  lsu_rdata;
    logic   lsu_rready;
    addr_t  lsu_awaddr;
    logic   lsu_awvalid;
    logic   lsu_awready;
    data_t  lsu_wdata;
    logic   lsu_wvalid;
    logic   lsu_wready;
    logic   lsu_bvalid;
    logic   lsu_bready;

    op_t    ops [$];
    addr_t  written [$];
    integer seed;
    int     timeouts = 0;
    int     check_errors;

    mem_subsys_top dut0 (
        .clk(clk), .rst(rst),
        .ifu_araddr(ifu_araddr), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
        .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata), .ifu_rready(ifu_rready),
        .lsu_araddr(lsu_araddr), .lsu_arvalid(lsu_arvalid), .lsu_arready(lsu_arready),
        .lsu_rvalid(lsu_rvalid), .lsu_rdata(lsu_rdata), .lsu_rready(lsu_rready),
        .lsu_awaddr(lsu_awaddr), .lsu_awvalid(lsu_awvalid), .lsu_awready(lsu_awready),
        .lsu_wdata(lsu_wdata), .lsu_wvalid(lsu_wvalid), .lsu_wready(lsu_wready),
        .lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready)
    );

    bus_checker chk0 (
        .clk(clk), .rst(rst),
        .ifu_araddr(ifu_araddr), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
        .ifu_rvalid(ifu_rvalid), .ifu_rdata(ifu_rdata), .ifu_rready(ifu_rready),
        .lsu_araddr(lsu_araddr), .lsu_arvalid(lsu_arvalid), .lsu_arready(lsu_arready),
        .lsu_rvalid(lsu_rvalid), .lsu_rdata(lsu_rdata), .lsu_rready(lsu_rready),
        .lsu_awaddr(lsu_awaddr), .lsu_awvalid(lsu_awvalid), .lsu_awready(lsu_awready),
        .lsu_wdata(lsu_wdata), .lsu_wvalid(lsu_wvalid), .lsu_wready(lsu_wready),
        .lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready),
        .error_count(check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic probe(input logic is_lsu, input wait_e what);
        case (what)
            ON_ARREADY: return is_lsu ? lsu_arready : ifu_arready;
            ON_RVALID:  return is_lsu ? lsu_rvalid : ifu_rvalid;
            ON_AWREADY: return lsu_awready;
            default:    return lsu_bvalid;
        endcase
    endfunction

    // returns right after the edge where the signal was seen high
    task automatic wait_for(input logic is_lsu, input wait_e what, input string desc);
        int   n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < TIMEOUT && !seen; n++) begin
            @(posedge clk);
            seen = (probe(is_lsu, what) === 1'b1);
        end
        if (!seen) begin
            $display("timeout: no %s within %0d cycles", desc, TIMEOUT);
            timeouts++;
        end
    endtask

    task automatic set_read(input logic is_lsu, input addr_t addr, input logic valid);
        if (is_lsu) begin
            lsu_araddr  <= addr;
            lsu_arvalid <= valid;
        end else begin
            ifu_araddr  <= addr;
            ifu_arvalid <= valid;
        end
    endtask

    task automatic set_rready(input logic is_lsu, input logic value);
        if (is_lsu) begin
            lsu_rready <= value;
        end else begin
            ifu_rready <= value;
        end
    endtask

    task automatic read_word(input logic is_lsu, input addr_t addr, input int stall);
        string pfx;
        pfx = is_lsu ? "lsu" : "ifu";
        set_read(is_lsu, addr, 1'b1);
        set_rready(is_lsu, stall == 0);
        wait_for(is_lsu, ON_ARREADY, {pfx, " read address handshake"});
        set_read(is_lsu, '0, 1'b0);
        wait_for(is_lsu, ON_RVALID, {pfx, " rvalid"});
        if (stall != 0) begin
            repeat (stall) @(posedge clk);
            set_rready(is_lsu, 1'b1);
            wait_for(is_lsu, ON_RVALID, {pfx, " read data handshake after the stall"});
        end
        set_rready(is_lsu, 1'b0);
    endtask

    task automatic lsu_write(input addr_t addr, input data_t data);
        lsu_awaddr  <= addr;
        lsu_awvalid <= 1'b1;
        lsu_wdata   <= data;
        lsu_wvalid  <= 1'b1;
        lsu_bready  <= 1'b1;
        wait_for(1'b1, ON_AWREADY, "lsu write address and data handshake");
        lsu_awvalid <= 1'b0;
        lsu_wvalid  <= 1'b0;
        wait_for(1'b1, ON_BVALID, "lsu write response");
        lsu_bready  <= 1'b0;
    endtask

    task automatic add_op(input logic is_lsu, input logic is_wr, input addr_t addr,
                          input int stall);
        op_t op;
        op.is_lsu = is_lsu;
        op.is_wr  = is_wr;
        op.addr   = addr;
        op.data   = $random(seed);
        op.stall  = stall;
        ops.push_back(op);
    endtask

    initial begin
        int    i;
        int    stall;
        addr_t a;

        rst         = 1'b1;
        ifu_araddr  = '0;
        ifu_arvalid = 1'b0;
        ifu_rready  = 1'b0;
        lsu_araddr  = '0;
        lsu_arvalid = 1'b0;
        lsu_rready  = 1'b0;
        lsu_awaddr  = '0;
        lsu_awvalid = 1'b0;
        lsu_wdata   = '0;
        lsu_wvalid  = 1'b0;
        lsu_bready  = 1'b0;
        seed        = 32'hcbd16eb0;

        add_op(1'b1, 1'b1, 32'h0000_0010, 0);
        add_op(1'b1, 1'b0, 32'h0000_0010, 0);
        add_op(1'b1, 1'b0, 32'h0000_1010, 3);   // differs only above bit 11
        add_op(1'b1, 1'b1, 32'h8000_0ffc, 0);
        add_op(1'b0, 1'b0, 32'h0000_0ffc, 0);
        add_op(1'b0, 1'b0, 32'h7654_3ffc, 2);
        for (i = 0; i < 6; i++) begin
            a = $random(seed);
            a[1:0] = 2'b00;
            add_op(1'b1, 1'b1, a, 0);
            add_op(1'b0, 1'b0, a ^ 32'h0004_0000, $unsigned($random(seed)) % 4);
            add_op(1'b1, 1'b0, a, $unsigned($random(seed)) % 4);
            written.push_back(a);
        end

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        repeat (GAP) @(posedge clk);

        foreach (ops[k]) begin
            if (ops[k].is_wr) begin
                lsu_write(ops[k].addr, ops[k].data);
            end else begin
                read_word(ops[k].is_lsu, ops[k].addr, ops[k].stall);
            end
            repeat (GAP) @(posedge clk);
        end

        // both masters request in the same cycle
        for (i = 0; i < written.size(); i++) begin
            stall = $unsigned($random(seed)) % 4;
            fork
                read_word(1'b0, written[i], 0);
                read_word(1'b1, written[(i + 1) % written.size()] | 32'h0010_0000, stall);
            join
            repeat (GAP) @(posedge clk);
        end

        repeat (4) @(posedge clk);
        $display("errors: checker %0d, timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
rtl/bus_pkg.sv
rtl/bus_arbiter.sv
rtl/bus_router.sv
rtl/axi_sram.sv
rtl/mem_subsys_top.sv
sim/bus_checker.sv
sim/tb_mem_subsys.sv
